//--- hw/t08_mem_pkg.sv
// t08 load/store subsystem shared types
// opcodes, func3 codes, handler states, address map and bus structs
package t08_mem_pkg;

    // major opcodes, only load, store and lui are executed
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_LUI   = 7'b0110111,
        OP_NOP   = 7'b0010011 // addi slot, treated as no-op
    } t08_opcode_e;

    // load sizes; stores reuse 0/1/2
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd4,
        LHU = 3'd5
    } t08_func3_e;

    localparam t08_func3_e SB = LB;
    localparam t08_func3_e SH = LH;
    localparam t08_func3_e SW = LW;

    // handler FSM, one bit
    typedef enum logic {
        H_DATA  = 1'b0,
        H_FETCH = 1'b1
    } t08_hstate_e;

    localparam logic [31:0] I2C_ADDRESS = 32'd923923; // lone peripheral register
    localparam logic [31:0] RAM_LIMIT   = 32'd2048;   // first byte past ram

    // handler -> memory
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
    } mem_req_t;

    // memory -> handler
    typedef struct packed {
        logic [31:0] rdata;
        logic        busy;
        logic        done;
    } mem_rsp_t;

    // core data command
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
        logic [2:0]  func3;
    } lsu_cmd_t;

endpackage

//--- hw/t08_handler.sv
// t08 memory handler
// shares the single memory port between pc fetch and load/store,
// sizes store data and extends load data by func3
`timescale 1ns/1ps

module t08_handler import t08_mem_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  lsu_cmd_t    cmd,
    input  logic [31:0] counter,
    input  mem_rsp_t    rsp,
    output mem_req_t    req,
    output logic [31:0] toreg,
    output logic [31:0] instruction,
    output logic        freeze
);

    t08_hstate_e state, next_state;
    logic [31:0] addressnew, tomem;          // bus address and sized store word
    logic [31:0] ld_ext;                     // extended load word
    logic [31:0] next_toreg, next_inst;
    logic        readout, writeout;
    logic        pend, next_pend;            // peripheral access in flight
    logic        is_periph, in_ram;

    assign is_periph = (cmd.addr == I2C_ADDRESS);
    assign in_ram    = (cmd.addr < RAM_LIMIT);

    // store word, sign taken from top of the field
    always_comb begin
        case (t08_func3_e'(cmd.func3))
            SB:      tomem = {{24{cmd.wdata[7]}}, cmd.wdata[7:0]};
            SH:      tomem = {{16{cmd.wdata[15]}}, cmd.wdata[15:0]};
            default: tomem = cmd.wdata; // sw
        endcase
    end

    // load extension on the returned word
    always_comb begin
        case (t08_func3_e'(cmd.func3))
            LB:      ld_ext = {{24{rsp.rdata[7]}}, rsp.rdata[7:0]};
            LH:      ld_ext = {{16{rsp.rdata[15]}}, rsp.rdata[15:0]};
            LBU:     ld_ext = {24'b0, rsp.rdata[7:0]};
            LHU:     ld_ext = {16'b0, rsp.rdata[15:0]};
            default: ld_ext = rsp.rdata; // lw and anything else whole
        endcase
    end

    always_comb begin
        next_state = state;
        next_toreg = toreg;
        next_inst  = instruction;
        next_pend  = pend;
        addressnew = counter;
        readout    = 1'b0;
        writeout   = 1'b0;
        case (state)
            H_DATA: begin
                next_state = H_FETCH;
                if (cmd.read | cmd.write) addressnew = cmd.addr;
                if (rsp.busy) begin
                    next_state = H_DATA;           // wait states
                end else if (pend) begin
                    // done cycle, bus stays quiet so the access is not repeated
                    if (rsp.done) begin
                        next_pend = 1'b0;
                        if (cmd.read) next_toreg = ld_ext;
                    end else begin
                        next_state = H_DATA;
                    end
                end else if (cmd.write) begin
                    writeout = 1'b1;
                    if (is_periph) begin
                        next_pend  = 1'b1;
                        next_state = H_DATA;
                    end
                end else if (cmd.read) begin
                    readout = 1'b1;
                    if (is_periph) begin
                        next_pend  = 1'b1;
                        next_state = H_DATA;
                    end else if (in_ram) begin
                        next_toreg = ld_ext;       // ram read is combinational
                    end
                end
            end
            H_FETCH: begin
                if (!rsp.busy) begin
                    readout    = 1'b1;
                    next_inst  = rsp.rdata;
                    next_state = H_DATA;
                end
            end
            default: next_state = H_DATA;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= H_DATA;
            pend        <= 1'b0;
            toreg       <= '0;
            instruction <= '0;
        end else begin
            state       <= next_state;
            pend        <= next_pend;
            toreg       <= next_toreg;
            instruction <= next_inst;
        end
    end

    assign freeze = rsp.busy | readout | writeout;

    assign req.addr  = addressnew;
    assign req.wdata = tomem;
    assign req.read  = readout;
    assign req.write = writeout;

endmodule

//--- hw/t08_mem_ctrl.sv
// t08 memory controller
// word ram for the low 2 KiB plus one peripheral register with wait states,
// boot write port for loading the program while the core is idle
`timescale 1ns/1ps

module t08_mem_ctrl import t08_mem_pkg::*; #(
    parameter int PERIPH_WAIT = 3,
    parameter int RAM_WORDS   = 512
) (
    input  logic        clk,
    input  logic        nrst,
    input  mem_req_t    req,
    output mem_rsp_t    rsp,
    input  logic        run,
    input  logic        boot_we,
    input  logic [31:0] boot_addr,
    input  logic [31:0] boot_data
);

    localparam int AW = $clog2(RAM_WORDS);       // word index width
    localparam int CW = $clog2(PERIPH_WAIT + 1); // wait counter width

    logic [31:0]   ram [RAM_WORDS];
    logic [31:0]   periph_reg;
    logic [CW-1:0] wait_cnt;
    logic          done_q;
    logic          req_ram, req_periph, start;

    assign req_ram    = (req.addr < RAM_LIMIT);
    assign req_periph = (req.addr == I2C_ADDRESS);

    // new peripheral access only when idle
    assign start = req_periph && (req.read || req.write) && (wait_cnt == '0) && !done_q;

    // ram write port, boot has priority while the core is held
    always_ff @(posedge clk) begin
        if (!run && boot_we) begin
            ram[boot_addr[AW+1:2]] <= boot_data;
        end else if (req.write && req_ram) begin
            ram[req.addr[AW+1:2]] <= req.wdata; // whole word
        end
    end

    always_ff @(posedge clk) begin
        if (start && req.write) periph_reg <= req.wdata; // captured at access start
    end

    // wait-state counter, done follows the last busy cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wait_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                wait_cnt <= PERIPH_WAIT[CW-1:0];
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
                if (wait_cnt == 1) done_q <= 1'b1;
            end
        end
    end

    // read data combinational on the address
    always_comb begin
        if (req_ram) rsp.rdata = ram[req.addr[AW+1:2]];
        else if (req_periph) rsp.rdata = periph_reg;
        else rsp.rdata = '0; // unmapped
    end

    assign rsp.busy = (wait_cnt != '0);
    assign rsp.done = done_q;

endmodule

//--- hw/t08_core_ctrl.sv
// t08 core sequencer
// pc, register file and load/store/lui decode, stepping in lockstep with the
// handler's fetch and data phases
`timescale 1ns/1ps

module t08_core_ctrl import t08_mem_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        run,
    input  logic [31:0] instruction,
    input  logic [31:0] toreg,
    input  logic        freeze,
    output lsu_cmd_t    cmd,
    output logic [31:0] counter
);

    // mirrors the handler: EXEC while it sits in DATA, FETCH for its fetch cycle
    typedef enum logic [1:0] {
        C_IDLE,
        C_EXEC,
        C_FETCH
    } t08_cstate_e;

    t08_cstate_e cstate;
    t08_opcode_e op;
    logic [31:0] rf [32];
    logic [31:0] pc;
    logic [4:0]  rd, rs1, rs2;
    logic [31:0] rs1_v, rs2_v;
    logic [31:0] imm_i, imm_s, imm_u;
    logic [4:0]  wb_rd;          // pending load target
    logic        wb_pend;
    logic        is_mem, step;

    assign op    = t08_opcode_e'(instruction[6:0]);
    assign rd    = instruction[11:7];
    assign rs1   = instruction[19:15];
    assign rs2   = instruction[24:20];
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_u = {instruction[31:12], 12'b0};

    assign rs1_v = (rs1 == 5'd0) ? 32'd0 : rf[rs1]; // x0 hardwired
    assign rs2_v = (rs2 == 5'd0) ? 32'd0 : rf[rs2];

    assign is_mem = (op == OP_LOAD) || (op == OP_STORE);

    // data command, only while executing
    always_comb begin
        cmd.addr  = rs1_v + ((op == OP_STORE) ? imm_s : imm_i);
        cmd.wdata = rs2_v;
        cmd.func3 = instruction[14:12];
        cmd.read  = (cstate == C_EXEC) && (op == OP_LOAD);
        cmd.write = (cstate == C_EXEC) && (op == OP_STORE);
    end

    // a peripheral access holds until freeze drops on its done cycle
    assign step = (cstate == C_EXEC) && (!is_mem || cmd.addr != I2C_ADDRESS || !freeze);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cstate  <= C_IDLE;
            pc      <= '0;
            wb_pend <= 1'b0;
            wb_rd   <= '0;
        end else begin
            case (cstate)
                C_IDLE: begin
                    // with no command pending freeze only rises in a fetch
                    if (run && freeze) cstate <= C_EXEC;
                end
                C_EXEC: begin
                    if (step) begin
                        pc      <= pc + 32'd4;
                        wb_pend <= (op == OP_LOAD);
                        wb_rd   <= rd;
                        cstate  <= C_FETCH;
                    end
                end
                C_FETCH: begin
                    wb_pend <= 1'b0; // written back this cycle
                    cstate  <= C_EXEC;
                end
                default: cstate <= C_IDLE;
            endcase
        end
    end

    // register file writes, lui at execute, loads once toreg is valid
    always_ff @(posedge clk) begin
        if (step && op == OP_LUI && rd != 5'd0) begin
            rf[rd] <= imm_u;
        end else if (cstate == C_FETCH && wb_pend && wb_rd != 5'd0) begin
            rf[wb_rd] <= toreg;
        end
    end

    assign counter = pc;

endmodule

//--- hw/t08_mem_top.sv
// t08 load/store subsystem top
// core, memory handler and memory controller, with boot port and bus trace
`timescale 1ns/1ps

module t08_mem_top import t08_mem_pkg::*; #(
    parameter int PERIPH_WAIT = 3,
    parameter int RAM_WORDS   = 512
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        run,
    input  logic        boot_we,
    input  logic [31:0] boot_addr,
    input  logic [31:0] boot_data,
    output logic        bus_write,
    output logic [31:0] bus_addr,
    output logic [31:0] bus_wdata,
    output logic [31:0] instruction,
    output logic        freeze
);

    lsu_cmd_t    cmd;
    mem_req_t    req;
    mem_rsp_t    rsp;
    logic [31:0] counter;   // fetch pc
    logic [31:0] toreg;     // extended load data

    t08_core_ctrl u_core (
        .clk         (clk),
        .nrst        (nrst),
        .run         (run),
        .instruction (instruction),
        .toreg       (toreg),
        .freeze      (freeze),
        .cmd         (cmd),
        .counter     (counter)
    );

    t08_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .cmd         (cmd),
        .counter     (counter),
        .rsp         (rsp),
        .req         (req),
        .toreg       (toreg),
        .instruction (instruction),
        .freeze      (freeze)
    );

    t08_mem_ctrl #(
        .PERIPH_WAIT (PERIPH_WAIT),
        .RAM_WORDS   (RAM_WORDS)
    ) u_mem (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .rsp       (rsp),
        .run       (run),
        .boot_we   (boot_we),
        .boot_addr (boot_addr),
        .boot_data (boot_data)
    );

    // bus trace
    assign bus_write = req.write;
    assign bus_addr  = req.addr;
    assign bus_wdata = req.wdata;

endmodule

//--- sim/t08_handler_props.sv
// t08 handler protocol checks
// bound into every t08_handler instance
`timescale 1ns/1ps

module t08_handler_props import t08_mem_pkg::*; (
    input logic        clk,
    input logic        nrst,
    input logic        readout,
    input logic        writeout,
    input logic [31:0] counter,
    input mem_rsp_t    rsp,
    input t08_hstate_e state,
    input logic [31:0] instruction
);

    // one bus direction per cycle
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(readout && writeout))
        else $error("handler drove read and write in the same cycle");

    // wait states stall the core through freeze, pc held
    a_busy_hold: assert property (@(posedge clk) disable iff (!nrst)
        rsp.busy |=> $stable(counter))
        else $error("pc moved during a peripheral wait state");

    // instruction register only loads on the FETCH -> DATA step
    a_inst_on_fetch: assert property (@(posedge clk) disable iff (!nrst)
        (instruction != $past(instruction)) |-> ($past(state) == H_FETCH))
        else $error("instruction changed outside a fetch");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(nrst) |-> (!readout && !writeout))
        else $error("bus active right after reset");

endmodule

bind t08_handler t08_handler_props u_props (
    .clk         (clk),
    .nrst        (nrst),
    .readout     (readout),
    .writeout    (writeout),
    .counter     (counter),
    .rsp         (rsp),
    .state       (state),
    .instruction (instruction)
);

//--- sim/t08_tb.sv
// t08 subsystem testbench
// boots the program image from the input file, runs the core and checks
// every store seen on the memory bus against the expected trace
`timescale 1ns/1ps

module t08_tb;

    localparam int RAM_WORDS = 512;
    localparam int MAX_EXP   = 64;

    logic        clk = 1'b0;
    logic        nrst;
    logic        run;
    logic        boot_we;
    logic [31:0] boot_addr, boot_data;
    logic        bus_write, freeze;
    logic [31:0] bus_addr, bus_wdata, instruction;

    logic [31:0] image [512];          // raw words of the input file
    logic [31:0] prog [RAM_WORDS];
    logic [31:0] exp_addr [MAX_EXP];
    logic [31:0] exp_data [MAX_EXP];
    int          n_prog, n_exp;
    int          store_idx = 0;        // next expected record
    int          err_cnt = 0;
    int          to_cnt = 0;
    int          cycles;
    int          fill_idx;             // tag of the word fetched at the end

    t08_mem_top #(
        .PERIPH_WAIT (3),
        .RAM_WORDS   (RAM_WORDS)
    ) dut (
        .clk         (clk),
        .nrst        (nrst),
        .run         (run),
        .boot_we     (boot_we),
        .boot_addr   (boot_addr),
        .boot_data   (boot_data),
        .bus_write   (bus_write),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .instruction (instruction),
        .freeze      (freeze)
    );

    always #5 clk = ~clk;

    // addi x0, x0, index, a no-op tagged with its own word index
    function automatic logic [31:0] filler_word(input int idx);
        return {idx[11:0], 13'd0, 7'b0010011};
    endfunction

    // store trace, sampled mid-cycle where the bus is stable
    always @(negedge clk) begin
        if (nrst && bus_write) begin
            if (!run) begin
                $display("error at %0t ns: store to %h while the core is idle", $time, bus_addr);
                err_cnt++;
            end else if (store_idx >= n_exp) begin
                $display("error at %0t ns: extra store to %h data %h", $time, bus_addr, bus_wdata);
                err_cnt++;
            end else begin
                if (bus_addr != exp_addr[store_idx]) begin
                    $display("error at %0t ns: store %0d address %h, expected %h",
                             $time, store_idx, bus_addr, exp_addr[store_idx]);
                    err_cnt++;
                end
                if (bus_wdata != exp_data[store_idx]) begin
                    $display("error at %0t ns: store %0d data %h, expected %h",
                             $time, store_idx, bus_wdata, exp_data[store_idx]);
                    err_cnt++;
                end
                store_idx++;
            end
        end
    end

    initial begin
        nrst      <= 1'b0;
        run       <= 1'b0;
        boot_we   <= 1'b0;
        boot_addr <= '0;
        boot_data <= '0;

        // count, program words, count, address/data pairs
        $readmemh("sim/t08_input.txt", image);
        n_prog = int'(image[0]);
        if (n_prog < 1 || n_prog > 200) begin
            $display("input file has a bad program word count");
            err_cnt++;
            n_prog = 0;
        end
        n_exp = int'(image[n_prog + 1]);
        if (n_exp < 1 || n_exp > MAX_EXP) begin
            $display("input file has a bad store record count");
            err_cnt++;
            n_exp = 0;
        end
        for (int i = 0; i < n_prog; i++) prog[i] = image[i + 1];
        for (int i = 0; i < n_exp; i++) begin
            exp_addr[i] = image[n_prog + 2 + 2 * i];
            exp_data[i] = image[n_prog + 3 + 2 * i];
        end

        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        repeat (20) @(posedge clk);    // quiet window, monitor flags any store

        // whole ram, program first then tagged no-ops
        for (int i = 0; i < RAM_WORDS; i++) begin
            @(posedge clk);
            boot_we   <= 1'b1;
            boot_addr <= 32'(i) << 2;
            boot_data <= (i < n_prog) ? prog[i] : filler_word(i);
        end
        @(posedge clk);
        boot_we <= 1'b0;
        repeat (4) @(posedge clk);     // a fetch picks up word 0
        @(negedge clk);
        if (n_prog > 0 && instruction != prog[0]) begin
            $display("error at %0t ns: fetched word %h before run, expected %h",
                     $time, instruction, prog[0]);
            err_cnt++;
        end
        @(posedge clk);
        run <= 1'b1;

        cycles = 0;
        while (store_idx < n_exp && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (store_idx < n_exp) begin
            $display("timeout: only %0d of %0d stores reached the bus", store_idx, n_exp);
            to_cnt++;
        end

        // freeze drops once the core is back on plain fetches
        cycles = 0;
        @(negedge clk);
        while (freeze && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (freeze) begin
            $display("timeout: freeze never dropped after the last store");
            to_cnt++;
        end
        repeat (40) @(negedge clk);    // trailing window for stray stores

        // past the program the core only walks the tagged no-ops
        fill_idx = int'(instruction[31:20]);
        if (fill_idx < n_prog || fill_idx >= RAM_WORDS ||
            instruction != filler_word(fill_idx)) begin
            $display("error at %0t ns: fetched word %h is not a filler past the program",
                     $time, instruction);
            err_cnt++;
        end

        $display("stores %0d of %0d, mismatches %0d, timeouts %0d",
                 store_idx, n_exp, err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/t08_input.txt
// hex words: program word count, then the words booted from byte 0 upward,
// then the store count, then one bus address / write data pair per store
1e
deadb0b7 60102023 abcd8137 60201223
60200423 07002183 07402203 60300623
60301823 60302a23 60400c23 60401e23
61400303 62602023 61404383 62702223
61401403 62802423 61405483 62902623
61402583 62b02823 000e22b7 9042a9a3
9132a503 62a02a23 9132c603 62c02c23
// data words at byte 0x70 and 0x74
8765c3a5 12345678
10
// lui and sizing of lui values
00000600 deadb000
00000604 ffff8000
00000608 00000000
// sizing of loaded data words
0000060c ffffffa5
00000610 ffffc3a5
00000614 8765c3a5
00000618 00000078
0000061c 00005678
// lb, lbu, lh, lhu, lw of the word at 0x614
00000620 ffffffa5
00000624 000000a5
00000628 ffffc3a5
0000062c 0000c3a5
00000630 8765c3a5
// peripheral store, load back, lbu back
000e1913 12345678
00000634 12345678
00000638 00000078

//--- flist.f
hw/t08_mem_pkg.sv
hw/t08_handler.sv
hw/t08_mem_ctrl.sv
hw/t08_core_ctrl.sv
hw/t08_mem_top.sv
sim/t08_handler_props.sv
sim/t08_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the t08 testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module t08_tb \
    -f flist.f --Mdir obj_dir -o t08_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/t08_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
